/* list.f */
+incdir+.
exu_pkg.sv
lane_if.sv
wb_issue_decoder.sv
fu.sv
result_collector.sv
exec_cluster.sv
tb_exec_cluster.sv

/* tb_exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module tb_exec_cluster;

  localparam int CLK_HALF_NS = 50;
  localparam int WATCHDOG_NS = 30 * 6 * 4 * 100; // Transactions, tests, cycles, period.
  localparam int ACK_LIMIT   = 8;
  localparam int ACK_NEGEDGE = 3; // Request sampled one edge after drive, ack one edge later.

  logic                   clk_i = 1'b0;
  logic                   arst_n_i;
  logic                   wb_cyc_i;
  logic                   wb_stb_i;
  logic                   wb_we_i;
  logic [`EXU_WB_AW-1:0]  wb_adr_i;
  logic [`EXU_XLEN-1:0]   wb_dat_i;
  wire  [`EXU_XLEN-1:0]   wb_dat_o;
  wire                    wb_ack_o;

  logic [31:0] shadow [`EXU_LANES][8]; // Expected descriptor of each lane.
  logic [31:0] rng_state   = 32'd91343;
  int          err_count   = 0;
  int          check_count = 0;
  int          test_count  = 0;
  int          test_errs   = 0;

  exec_cluster dut_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  always #(CLK_HALF_NS) clk_i = ~clk_i;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // ==============================
  // Wishbone master
  // ==============================
  task automatic bus_cycle(input int lane, input logic [2:0] field, input logic we,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    logic [`EXU_LANE_AW-1:0] lane_bits;
    int                      cycles;
    lane_bits = lane[`EXU_LANE_AW-1:0];
    cycles    = 0;
    rdata     = '0;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= {lane_bits, field};
    wb_dat_i <= wdata;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!wb_ack_o && cycles < ACK_LIMIT);
    if (wb_ack_o) begin
      rdata = wb_dat_o; // Stable mid-cycle.
      assert (cycles == ACK_NEGEDGE) else begin
        $display("Acknowledge for lane %0d field %0d came at falling edge %0d instead of %0d",
                 lane, field, cycles, ACK_NEGEDGE);
        err_count++;
      end
    end else begin
      $display("No acknowledge for lane %0d field %0d within %0d cycles",
               lane, field, ACK_LIMIT);
      err_count++;
    end
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    @(negedge clk_i);
    assert (!wb_ack_o) else begin
      $display("Acknowledge for lane %0d field %0d stayed high for more than one cycle",
               lane, field);
      err_count++;
    end
  endtask

  task automatic write_field(input int lane, input logic [2:0] field, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(lane, field, 1'b1, data, unused);
    case (field)
      `EXU_FIELD_TYPE:   shadow[lane][field] = {29'd0, data[2:0]};
      `EXU_FIELD_OP:     shadow[lane][field] = {28'd0, data[3:0]};
      `EXU_FIELD_RESULT: ; // Read-only slot.
      default:           shadow[lane][field] = data;
    endcase
  endtask

  // ==============================
  // Reference model
  // ==============================
  task automatic model_result(input int lane, output logic [31:0] res);
    logic [2:0]  t;
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    t   = shadow[lane][`EXU_FIELD_TYPE][2:0];
    op  = shadow[lane][`EXU_FIELD_OP][3:0];
    a   = '0;
    b   = '0;
    res = '0;
    if (t != exu_pkg::INST_NOP && op != exu_pkg::ALU_OP_NOP) begin
      case (t)
        exu_pkg::INST_RR: begin
          a = shadow[lane][`EXU_FIELD_RDATA1];
          b = shadow[lane][`EXU_FIELD_RDATA2];
        end
        exu_pkg::INST_RI: begin
          a = shadow[lane][`EXU_FIELD_RDATA1];
          b = shadow[lane][`EXU_FIELD_IMM];
        end
        exu_pkg::INST_LUI:   b = shadow[lane][`EXU_FIELD_IMM];
        exu_pkg::INST_AUIPC: begin
          a = shadow[lane][`EXU_FIELD_PC];
          b = shadow[lane][`EXU_FIELD_IMM];
        end
        exu_pkg::INST_JAL,
        exu_pkg::INST_JALR:  a = shadow[lane][`EXU_FIELD_PC];
        exu_pkg::INST_CSRR:  a = shadow[lane][`EXU_FIELD_CSR];
        default: ;
      endcase
      sh = b[4:0];
      case (op)
        exu_pkg::ALU_OP_ADD,
        exu_pkg::ALU_OP_LUI,
        exu_pkg::ALU_OP_AUIPC: res = a + b;
        exu_pkg::ALU_OP_SUB:   res = a - b;
        exu_pkg::ALU_OP_XOR:   res = a ^ b;
        exu_pkg::ALU_OP_OR:    res = a | b;
        exu_pkg::ALU_OP_AND:   res = a & b;
        exu_pkg::ALU_OP_SLL:   res = a << sh;
        exu_pkg::ALU_OP_SRL:   res = a >> sh;
        exu_pkg::ALU_OP_SRA:   res = (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
        exu_pkg::ALU_OP_SLT:   res = {31'd0, $signed(a) < $signed(b)};
        exu_pkg::ALU_OP_SLTU:  res = {31'd0, a < b};
        exu_pkg::ALU_OP_JUMP:  res = a + 32'd4;
        exu_pkg::ALU_OP_CSRR:  res = a;
        default:               res = '0;
      endcase
    end
  endtask

  task automatic check_word(input int lane, input logic [2:0] field);
    logic [31:0] exp;
    logic [31:0] got;
    if (field == `EXU_FIELD_RESULT) begin
      model_result(lane, exp);
    end else begin
      exp = shadow[lane][field];
    end
    bus_cycle(lane, field, 1'b0, 32'd0, got);
    check_count++;
    assert (got == exp) else begin
      $display("ERROR: wb_dat_o lane %0d field %0d expected 0x%08h got 0x%08h",
               lane, field, exp, got);
      err_count++;
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    $display("Test %0d %-24s %s, %0d error(s)", test_count, name,
             (err_count == test_errs) ? "passed" : "FAILED", err_count - test_errs);
    test_errs = err_count;
  endtask

  // ==============================
  // Tests
  // ==============================
  initial begin
    logic [31:0] rd1;
    logic [31:0] rd2;
    int          lane;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    wb_adr_i <= '0;
    wb_dat_i <= '0;
    arst_n_i <= 1'b0;
    for (int l = 0; l < `EXU_LANES; l++) begin
      for (int f = 0; f < 8; f++) begin
        shadow[l][f] = '0;
      end
    end
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;

    for (int l = 0; l < `EXU_LANES; l++) begin
      for (int f = 0; f < 8; f++) begin
        check_word(l, 3'(f));
      end
    end
    report_test("reset state");

    // Ops ADD..SLTU rotate over lanes; lanes 1..3 get the shift corner cases.
    for (int l = 0; l < `EXU_LANES; l++) begin
      rd1 = next_random();
      rd2 = next_random();
      if (l == 3) rd1[31] = 1'b1;
      if (l == 1) rd2[4:0] = 5'd0;
      if (l >= 2) rd2[4:0] = 5'd31;
      write_field(l, `EXU_FIELD_TYPE, 32'(exu_pkg::INST_RR));
      write_field(l, `EXU_FIELD_RDATA1, rd1);
      write_field(l, `EXU_FIELD_RDATA2, rd2);
    end
    for (int k = 0; k < 10; k++) begin
      lane = k % `EXU_LANES;
      write_field(lane, `EXU_FIELD_OP, int'(exu_pkg::ALU_OP_ADD) + k);
      check_word(lane, `EXU_FIELD_RESULT);
    end
    report_test("register-register ops");

    write_field(1, `EXU_FIELD_TYPE, 32'(exu_pkg::INST_RI));
    write_field(1, `EXU_FIELD_OP, 32'(exu_pkg::ALU_OP_ADD));
    write_field(1, `EXU_FIELD_IMM, next_random());
    check_word(1, `EXU_FIELD_RESULT);
    write_field(1, `EXU_FIELD_OP, 32'(exu_pkg::ALU_OP_XOR));
    check_word(1, `EXU_FIELD_RESULT);
    write_field(2, `EXU_FIELD_TYPE, 32'(exu_pkg::INST_LUI));
    write_field(2, `EXU_FIELD_OP, 32'(exu_pkg::ALU_OP_LUI));
    write_field(2, `EXU_FIELD_IMM, next_random() & 32'hFFFF_F000); // rdata1 stays nonzero.
    check_word(2, `EXU_FIELD_RESULT);
    write_field(3, `EXU_FIELD_TYPE, 32'(exu_pkg::INST_AUIPC));
    write_field(3, `EXU_FIELD_OP, 32'(exu_pkg::ALU_OP_AUIPC));
    write_field(3, `EXU_FIELD_PC, next_random() & 32'hFFFF_FFFC);
    write_field(3, `EXU_FIELD_IMM, next_random() & 32'hFFFF_F000);
    check_word(3, `EXU_FIELD_RESULT);
    report_test("immediate forms");

    write_field(0, `EXU_FIELD_TYPE, 32'(exu_pkg::INST_JAL));
    write_field(0, `EXU_FIELD_OP, 32'(exu_pkg::ALU_OP_JUMP));
    write_field(0, `EXU_FIELD_PC, next_random() & 32'hFFFF_FFFC);
    check_word(0, `EXU_FIELD_RESULT);
    write_field(1, `EXU_FIELD_TYPE, 32'(exu_pkg::INST_JALR));
    write_field(1, `EXU_FIELD_OP, 32'(exu_pkg::ALU_OP_JUMP));
    write_field(1, `EXU_FIELD_PC, 32'hFFFF_FFFC); // Link address wraps.
    check_word(1, `EXU_FIELD_RESULT);
    write_field(2, `EXU_FIELD_TYPE, 32'(exu_pkg::INST_CSRR));
    write_field(2, `EXU_FIELD_OP, 32'(exu_pkg::ALU_OP_CSRR));
    write_field(2, `EXU_FIELD_CSR, next_random());
    check_word(2, `EXU_FIELD_RESULT);
    report_test("jumps and csr reads");

    write_field(3, `EXU_FIELD_TYPE, 32'(exu_pkg::INST_NOP));
    check_word(3, `EXU_FIELD_RESULT);
    write_field(0, `EXU_FIELD_OP, 32'(exu_pkg::ALU_OP_NOP));
    check_word(0, `EXU_FIELD_RESULT);
    write_field(1, `EXU_FIELD_OP, 32'h0000_00FF); // Truncates to the unused op.
    check_word(1, `EXU_FIELD_RESULT);
    check_word(1, `EXU_FIELD_OP);
    write_field(2, `EXU_FIELD_TYPE, 32'(exu_pkg::INST_LUI));
    check_word(2, `EXU_FIELD_RESULT);
    report_test("nop and unknown pairs");

    // Types RR..AUIPC with ops SUB, AND, SRA, LUI for a 4-lane build.
    for (int l = 0; l < `EXU_LANES; l++) begin
      write_field(l, `EXU_FIELD_TYPE, l + 1);
      write_field(l, `EXU_FIELD_OP, 3 * l + 2);
      write_field(l, `EXU_FIELD_PC, next_random());
      write_field(l, `EXU_FIELD_IMM, next_random());
      write_field(l, `EXU_FIELD_RDATA1, next_random());
      write_field(l, `EXU_FIELD_RDATA2, next_random());
      write_field(l, `EXU_FIELD_CSR, next_random());
    end
    for (int l = 0; l < `EXU_LANES; l++) begin
      for (int f = 0; f < 8; f++) begin
        check_word(l, 3'(f));
      end
    end
    write_field(0, `EXU_FIELD_RESULT, next_random());
    check_word(0, `EXU_FIELD_RESULT);
    report_test("lane independence");

    $display("Tests run: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module exec_cluster (
  input  wire                    clk_i,
  input  wire                    arst_n_i,
  input  wire                    wb_cyc_i,
  input  wire                    wb_stb_i,
  input  wire                    wb_we_i,
  input  wire [`EXU_WB_AW-1:0]   wb_adr_i,
  input  wire [`EXU_XLEN-1:0]    wb_dat_i,
  output wire [`EXU_XLEN-1:0]    wb_dat_o,
  output wire                    wb_ack_o
);

  wire [`EXU_LANE_AW-1:0]   rd_lane;
  wire [`EXU_FIELD_AW-1:0]  rd_field;
  wire                      rd_load;

  lane_if lanes [`EXU_LANES] ();

  // ==============================
  // Issue side
  // ==============================
  wb_issue_decoder decoder_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_o   (wb_ack_o),
    .lane_o     (lanes),
    .rd_lane_o  (rd_lane),
    .rd_field_o (rd_field),
    .rd_load_o  (rd_load)
  );

  // ==============================
  // Execute lanes
  // ==============================
  for (genvar g = 0; g < `EXU_LANES; g++) begin : g_fu
    fu fu_i (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .lane     (lanes[g])
    );
  end

  // ==============================
  // Read side
  // ==============================
  result_collector collector_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .rd_lane_i  (rd_lane),
    .rd_field_i (rd_field),
    .rd_load_i  (rd_load),
    .lane_i     (lanes),
    .wb_dat_o   (wb_dat_o)
  );

endmodule

`default_nettype wire

/* result_collector.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module result_collector (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  wire [`EXU_LANE_AW-1:0]    rd_lane_i,
  input  wire [`EXU_FIELD_AW-1:0]   rd_field_i,
  input  wire                       rd_load_i,
  lane_if.coll                      lane_i [`EXU_LANES],
  output logic [`EXU_XLEN-1:0]      wb_dat_o
);

  exu_pkg::issue_t        issue_a  [`EXU_LANES];
  logic [`EXU_XLEN-1:0]   result_a [`EXU_LANES];
  exu_pkg::issue_t        sel_issue;
  logic [`EXU_XLEN-1:0]   sel_result;
  logic [`EXU_XLEN-1:0]   rd_data;

  for (genvar g = 0; g < `EXU_LANES; g++) begin : g_tap
    assign issue_a[g]  = lane_i[g].issue;
    assign result_a[g] = lane_i[g].result;
  end

  // Unpopulated lanes read as zero.
  always_comb begin
    sel_issue  = '0;
    sel_result = '0;
    if (int'(rd_lane_i) < `EXU_LANES) begin
      sel_issue  = issue_a[rd_lane_i];
      sel_result = result_a[rd_lane_i];
    end
  end

  always_comb begin
    case (rd_field_i)
      `EXU_FIELD_TYPE:   rd_data = `EXU_XLEN'(sel_issue.inst_type); // Zero-extended.
      `EXU_FIELD_OP:     rd_data = `EXU_XLEN'(sel_issue.alu_op);
      `EXU_FIELD_PC:     rd_data = sel_issue.pc;
      `EXU_FIELD_IMM:    rd_data = sel_issue.imm;
      `EXU_FIELD_RDATA1: rd_data = sel_issue.rdata1;
      `EXU_FIELD_RDATA2: rd_data = sel_issue.rdata2;
      `EXU_FIELD_CSR:    rd_data = sel_issue.csr;
      default:           rd_data = sel_result;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_dat_o <= '0;
    end else if (rd_load_i) begin
      wb_dat_o <= rd_data; // Valid with ack.
    end
  end

endmodule

`default_nettype wire

/* fu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module fu (
  input  wire   clk_i,
  input  wire   arst_n_i,
  lane_if.unit  lane
);

  exu_pkg::issue_t        iss;
  logic                   is_nop;
  logic [`EXU_XLEN-1:0]   op1;
  logic [`EXU_XLEN-1:0]   op2;
  logic [4:0]             shamt;
  logic [`EXU_XLEN-1:0]   alu_res;
  logic [`EXU_XLEN-1:0]   result_q;

  assign iss    = lane.issue;
  assign is_nop = (iss.inst_type == exu_pkg::INST_NOP) ||
                  (iss.alu_op == exu_pkg::ALU_OP_NOP);

  // ==============================
  // Operand select
  // ==============================
  always_comb begin
    op1 = '0;
    if (!is_nop) begin
      case (iss.inst_type)
        exu_pkg::INST_RR,
        exu_pkg::INST_RI:    op1 = iss.rdata1;
        exu_pkg::INST_AUIPC,
        exu_pkg::INST_JAL,
        exu_pkg::INST_JALR:  op1 = iss.pc;
        exu_pkg::INST_CSRR:  op1 = iss.csr;
        default:             op1 = '0; // LUI adds imm to zero.
      endcase
    end
  end

  always_comb begin
    op2 = '0;
    if (!is_nop) begin
      case (iss.inst_type)
        exu_pkg::INST_RR:    op2 = iss.rdata2;
        exu_pkg::INST_RI,
        exu_pkg::INST_LUI,
        exu_pkg::INST_AUIPC: op2 = iss.imm;
        default:             op2 = '0;
      endcase
    end
  end

  assign shamt = op2[4:0];

  // ==============================
  // ALU
  // ==============================
  always_comb begin
    alu_res = '0;
    if (!is_nop) begin
      case (iss.alu_op)
        exu_pkg::ALU_OP_ADD,
        exu_pkg::ALU_OP_LUI,
        exu_pkg::ALU_OP_AUIPC: alu_res = op1 + op2;
        exu_pkg::ALU_OP_SUB:   alu_res = op1 - op2;
        exu_pkg::ALU_OP_XOR:   alu_res = op1 ^ op2;
        exu_pkg::ALU_OP_OR:    alu_res = op1 | op2;
        exu_pkg::ALU_OP_AND:   alu_res = op1 & op2;
        exu_pkg::ALU_OP_SLL:   alu_res = op1 << shamt;
        exu_pkg::ALU_OP_SRL:   alu_res = op1 >> shamt;
        exu_pkg::ALU_OP_SRA:   alu_res = $signed(op1) >>> shamt; // Sign fill.
        exu_pkg::ALU_OP_SLT:   alu_res = {{(`EXU_XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
        exu_pkg::ALU_OP_SLTU:  alu_res = {{(`EXU_XLEN-1){1'b0}}, op1 < op2};
        exu_pkg::ALU_OP_JUMP:  alu_res = op1 + `EXU_XLEN'(4); // Link address.
        exu_pkg::ALU_OP_CSRR:  alu_res = op1;
        default:               alu_res = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_q <= '0;
    end else begin
      result_q <= alu_res; // Follows the descriptor one edge later.
    end
  end

  assign lane.result = result_q;

endmodule

`default_nettype wire

/* wb_issue_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

module wb_issue_decoder (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  wire                       wb_cyc_i,
  input  wire                       wb_stb_i,
  input  wire                       wb_we_i,
  input  wire [`EXU_WB_AW-1:0]      wb_adr_i,
  input  wire [`EXU_XLEN-1:0]       wb_dat_i,
  output logic                      wb_ack_o,
  lane_if.disp                      lane_o [`EXU_LANES],
  output logic [`EXU_LANE_AW-1:0]   rd_lane_o,
  output logic [`EXU_FIELD_AW-1:0]  rd_field_o,
  output logic                      rd_load_o
);

  logic                       req;
  logic                       start;
  logic                       armed_q;  // Set once stb has been seen low.
  logic                       seen_q;
  logic                       ack_q;
  logic                       wr_en;
  logic [`EXU_LANE_AW-1:0]    acc_lane;
  logic [`EXU_FIELD_AW-1:0]   acc_field;
  exu_pkg::issue_t            desc_q [`EXU_LANES];

  assign req       = wb_cyc_i & wb_stb_i;
  assign start     = req & armed_q;
  assign acc_lane  = wb_adr_i[`EXU_WB_AW-1:`EXU_FIELD_AW];
  assign acc_field = wb_adr_i[`EXU_FIELD_AW-1:0];

  // ==============================
  // Handshake
  // ==============================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      armed_q <= 1'b1;
      seen_q  <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      seen_q <= start;
      ack_q  <= seen_q & req; // Dropped if the master aborts.
      if (start) begin
        armed_q <= 1'b0;
      end else if (!req) begin
        armed_q <= 1'b1;
      end
    end
  end

  assign wb_ack_o = ack_q;

  // Master holds address and data until ack.
  assign wr_en      = seen_q & req & wb_we_i;
  assign rd_load_o  = seen_q & req & ~wb_we_i;
  assign rd_lane_o  = acc_lane;
  assign rd_field_o = acc_field;

  // ==============================
  // Descriptor registers
  // ==============================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `EXU_LANES; i++) begin
        desc_q[i] <= '0;
      end
    end else if (wr_en) begin
      for (int i = 0; i < `EXU_LANES; i++) begin
        if (int'(acc_lane) == i) begin
          case (acc_field)
            `EXU_FIELD_TYPE:   desc_q[i].inst_type <= exu_pkg::inst_type_e'(wb_dat_i[2:0]);
            `EXU_FIELD_OP:     desc_q[i].alu_op    <= exu_pkg::alu_op_e'(wb_dat_i[3:0]);
            `EXU_FIELD_PC:     desc_q[i].pc        <= wb_dat_i;
            `EXU_FIELD_IMM:    desc_q[i].imm       <= wb_dat_i;
            `EXU_FIELD_RDATA1: desc_q[i].rdata1    <= wb_dat_i;
            `EXU_FIELD_RDATA2: desc_q[i].rdata2    <= wb_dat_i;
            `EXU_FIELD_CSR:    desc_q[i].csr       <= wb_dat_i;
            default: ;                              // Result slot ignores writes.
          endcase
        end
      end
    end
  end

  for (genvar g = 0; g < `EXU_LANES; g++) begin : g_lane
    assign lane_o[g].issue = desc_q[g];
  end

endmodule

`default_nettype wire

/* lane_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defs.svh"

// One execute lane: descriptor in, registered result out.
interface lane_if;

  exu_pkg::issue_t        issue;  // From the issue decoder.
  logic [`EXU_XLEN-1:0]   result; // From the functional unit.

  modport disp (
    output issue
  );

  modport unit (
    input  issue,
    output result
  );

  // Collector reads both for readback.
  modport coll (
    input  issue,
    input  result
  );

endinterface

`default_nettype wire

/* exu_pkg.sv */
`default_nettype none
`include "exu_defs.svh"

package exu_pkg;

  // ==============================
  // Decode encodings
  // ==============================
  typedef enum logic [2:0] {
    INST_NOP   = 3'd0,
    INST_RR    = 3'd1,
    INST_RI    = 3'd2,
    INST_LUI   = 3'd3,
    INST_AUIPC = 3'd4,
    INST_JAL   = 3'd5,
    INST_JALR  = 3'd6,
    INST_CSRR  = 3'd7
  } inst_type_e;

  typedef enum logic [3:0] {
    ALU_OP_NOP   = 4'd0,
    ALU_OP_ADD   = 4'd1,
    ALU_OP_SUB   = 4'd2,
    ALU_OP_XOR   = 4'd3,
    ALU_OP_OR    = 4'd4,
    ALU_OP_AND   = 4'd5,
    ALU_OP_SLL   = 4'd6,
    ALU_OP_SRL   = 4'd7,
    ALU_OP_SRA   = 4'd8,
    ALU_OP_SLT   = 4'd9,
    ALU_OP_SLTU  = 4'd10,
    ALU_OP_LUI   = 4'd11,
    ALU_OP_AUIPC = 4'd12,
    ALU_OP_JUMP  = 4'd13,
    ALU_OP_CSRR  = 4'd14
  } alu_op_e; // 4'd15 is unused.

  // ==============================
  // Issue descriptor
  // ==============================
  typedef struct packed {
    inst_type_e            inst_type;
    alu_op_e               alu_op;
    logic [`EXU_XLEN-1:0]  pc;
    logic [`EXU_XLEN-1:0]  imm;
    logic [`EXU_XLEN-1:0]  rdata1;
    logic [`EXU_XLEN-1:0]  rdata2;
    logic [`EXU_XLEN-1:0]  csr;
  } issue_t;

endpackage

`default_nettype wire

/* exu_defs.svh */
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// ==============================
// Cluster geometry
// ==============================
`define EXU_LANES       4
`define EXU_XLEN        32

// Word address is {lane, field}. Widen EXU_LANE_AW for 8 lanes.
`define EXU_LANE_AW     2
`define EXU_FIELD_AW    3
`define EXU_WB_AW       (`EXU_LANE_AW + `EXU_FIELD_AW)

// ==============================
// Field offsets in a lane window
// ==============================
`define EXU_FIELD_TYPE    3'd0
`define EXU_FIELD_OP      3'd1
`define EXU_FIELD_PC      3'd2
`define EXU_FIELD_IMM     3'd3
`define EXU_FIELD_RDATA1  3'd4
`define EXU_FIELD_RDATA2  3'd5
`define EXU_FIELD_CSR     3'd6
`define EXU_FIELD_RESULT  3'd7 // Read-only.

`endif
